// ==== common/light_grid_pkg.sv ====
`default_nettype none

package light_grid_pkg;

    // Grid and stream sizes.
    localparam int GRID_SIZE = 1000;
    localparam int POSITION_WIDTH = 10;
    localparam int CHAR_WIDTH = 8;
    localparam int COUNT_WIDTH = 20; // Holds GRID_SIZE squared.
    localparam int QUEUE_DEPTH = 8;

    // ASCII codes the decoder cares about.
    typedef enum logic [CHAR_WIDTH-1:0] {
        CHAR_NUL   = 8'h00,
        CHAR_LF    = 8'h0A,
        CHAR_SPACE = 8'h20,
        CHAR_COMMA = 8'h2C,
        CHAR_ZERO  = 8'h30,
        CHAR_NINE  = 8'h39,
        CHAR_F     = 8'h66,
        CHAR_N     = 8'h6E,
        CHAR_O     = 8'h6F,
        CHAR_T     = 8'h74
    } char_t;

    typedef enum logic [1:0] {
        OP_OFF    = 2'b00,
        OP_TOGGLE = 2'b01,
        OP_ON     = 2'b11
    } op_t;

    // One normalized line of the input file.
    typedef struct packed {
        logic                      last;
        op_t                       op;
        logic [POSITION_WIDTH-1:0] start_row;
        logic [POSITION_WIDTH-1:0] start_col;
        logic [POSITION_WIDTH-1:0] end_row;
        logic [POSITION_WIDTH-1:0] end_col;
    } instr_t;

endpackage

`default_nettype wire

// ==== hdl/line_decoder.sv ====
`default_nettype none

module line_decoder (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  in_valid,
    input  logic [light_grid_pkg::CHAR_WIDTH-1:0] in_data,
    output logic                                  end_of_file,
    output logic                                  instr_valid,
    output light_grid_pkg::instr_t                instr
);

    typedef enum logic [1:0] {
        FIELD_START_ROW,
        FIELD_START_COL,
        FIELD_END_ROW,
        FIELD_END_COL
    } field_t;

    field_t                                     field;
    logic [light_grid_pkg::CHAR_WIDTH-1:0]      prev_char;
    logic [light_grid_pkg::CHAR_WIDTH-1:0]      delimiter;
    light_grid_pkg::op_t                        op;
    logic [light_grid_pkg::POSITION_WIDTH-1:0]  acc;
    logic [light_grid_pkg::POSITION_WIDTH-1:0]  acc_next;
    logic [light_grid_pkg::POSITION_WIDTH-1:0]  digit;
    logic [light_grid_pkg::POSITION_WIDTH-1:0]  start_row;
    logic [light_grid_pkg::POSITION_WIDTH-1:0]  start_col;
    logic [light_grid_pkg::POSITION_WIDTH-1:0]  end_row;
    logic [light_grid_pkg::POSITION_WIDTH-1:0]  end_col;
    logic                                       in_digit;
    logic                                       prev_digit;
    logic                                       field_done;
    logic                                       issue;

    assign in_digit = (in_data >= light_grid_pkg::CHAR_ZERO) &&
                      (in_data <= light_grid_pkg::CHAR_NINE);
    assign prev_digit = (prev_char >= light_grid_pkg::CHAR_ZERO) &&
                        (prev_char <= light_grid_pkg::CHAR_NINE);
    assign digit = light_grid_pkg::POSITION_WIDTH'(in_data - light_grid_pkg::CHAR_ZERO);

    // A new number restarts on its first digit.
    assign acc_next = prev_digit ? acc * light_grid_pkg::POSITION_WIDTH'(10) + digit : digit;

    always_comb begin
        case (field)
            FIELD_START_ROW: delimiter = light_grid_pkg::CHAR_COMMA;
            FIELD_START_COL: delimiter = light_grid_pkg::CHAR_SPACE;
            FIELD_END_ROW:   delimiter = light_grid_pkg::CHAR_COMMA;
            default:         delimiter = light_grid_pkg::CHAR_LF;
        endcase
    end

    assign field_done = in_valid && (in_data == delimiter);
    assign issue = in_valid && (prev_char == light_grid_pkg::CHAR_LF); // Line is complete.

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_char <= light_grid_pkg::CHAR_SPACE;
            field <= FIELD_START_ROW;
            op <= light_grid_pkg::OP_OFF;
        end else if (in_valid) begin
            prev_char <= in_data;
            if (field_done) begin
                field <= field_t'(field + 2'd1); // Wraps back to start row on LF.
            end
            case ({prev_char, in_data})
                {light_grid_pkg::CHAR_O, light_grid_pkg::CHAR_F}: op <= light_grid_pkg::OP_OFF;
                {light_grid_pkg::CHAR_T, light_grid_pkg::CHAR_O}: op <= light_grid_pkg::OP_TOGGLE;
                {light_grid_pkg::CHAR_O, light_grid_pkg::CHAR_N}: op <= light_grid_pkg::OP_ON;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_digit) begin
            acc <= acc_next;
        end
    end

    // Each field is written once per line, by its closing delimiter.
    always_ff @(posedge clk) begin
        if (field_done) begin
            case (field)
                FIELD_START_ROW: start_row <= acc;
                FIELD_START_COL: start_col <= acc;
                FIELD_END_ROW:   end_row <= acc;
                default:         end_col <= acc;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            instr_valid <= 1'b0;
            end_of_file <= 1'b0;
        end else begin
            instr_valid <= issue;
            if (in_valid && prev_char == light_grid_pkg::CHAR_NUL &&
                in_data == light_grid_pkg::CHAR_NUL) begin
                end_of_file <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            instr <= '{
                last:      (in_data == light_grid_pkg::CHAR_NUL),
                op:        op,
                start_row: start_row,
                start_col: start_col,
                end_row:   end_row,
                end_col:   end_col
            };
        end
    end

endmodule

`default_nettype wire

// ==== hdl/instr_queue.sv ====
`default_nettype none

module instr_queue (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   push,
    input  light_grid_pkg::instr_t push_data,
    input  logic                   pop,
    output light_grid_pkg::instr_t head,
    output logic                   not_empty,
    output logic                   stall
);

    typedef logic [$clog2(light_grid_pkg::QUEUE_DEPTH)-1:0] ptr_t;
    typedef logic [$clog2(light_grid_pkg::QUEUE_DEPTH+1)-1:0] count_t;

    light_grid_pkg::instr_t mem [light_grid_pkg::QUEUE_DEPTH];
    ptr_t   wr_ptr;
    ptr_t   rd_ptr;
    count_t count;
    count_t free_entries;

    function automatic ptr_t next_ptr(input ptr_t ptr);
        return (ptr == ptr_t'(light_grid_pkg::QUEUE_DEPTH - 1)) ? '0 : ptr + ptr_t'(1);
    endfunction

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + count_t'(1);
                2'b01:   count <= count - count_t'(1);
                default: ;
            endcase
        end
    end

    assign head = mem[rd_ptr];
    assign not_empty = (count != '0);
    assign free_entries = count_t'(light_grid_pkg::QUEUE_DEPTH) - count;
    assign stall = (free_entries <= count_t'(1)); // Leaves room for one in-flight line.

endmodule

`default_nettype wire

// ==== grid_engine/row_memory.sv ====
`default_nettype none

module row_memory (
    input  logic                                      clk,
    input  logic [light_grid_pkg::POSITION_WIDTH-1:0] rd_addr,
    output logic [light_grid_pkg::GRID_SIZE-1:0]      rd_data,
    input  logic                                      wr_en,
    input  logic [light_grid_pkg::POSITION_WIDTH-1:0] wr_addr,
    input  logic [light_grid_pkg::GRID_SIZE-1:0]      wr_data
);

    // One word per grid row, bit index is the column.
    logic [light_grid_pkg::GRID_SIZE-1:0] mem [light_grid_pkg::GRID_SIZE];

    // Registered read, old data on a same-address write.
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== grid_engine/grid_engine.sv ====
`default_nettype none

module grid_engine (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   not_empty,
    input  light_grid_pkg::instr_t                 head,
    output logic                                   pop,
    output logic                                   idle,
    output logic [light_grid_pkg::COUNT_WIDTH-1:0] lit_count
);

    typedef enum logic [1:0] {
        ST_CLEAR,
        ST_WAIT,
        ST_READ,
        ST_WRITE
    } state_t;

    state_t                                    state;
    light_grid_pkg::op_t                       op;
    logic [light_grid_pkg::POSITION_WIDTH-1:0] row;
    logic [light_grid_pkg::POSITION_WIDTH-1:0] end_row;
    logic [light_grid_pkg::GRID_SIZE-1:0]      mask;
    logic [light_grid_pkg::GRID_SIZE-1:0]      rd_data;
    logic [light_grid_pkg::GRID_SIZE-1:0]      new_row;
    logic [light_grid_pkg::GRID_SIZE-1:0]      wr_data;
    logic                                      wr_en;
    logic [light_grid_pkg::COUNT_WIDTH-1:0]    ones_new;
    logic [light_grid_pkg::COUNT_WIDTH-1:0]    ones_old;
    logic                                      count_pending;

    function automatic logic [light_grid_pkg::GRID_SIZE-1:0] column_mask(
        input logic [light_grid_pkg::POSITION_WIDTH-1:0] first,
        input logic [light_grid_pkg::POSITION_WIDTH-1:0] last
    );
        logic [light_grid_pkg::GRID_SIZE-1:0] m;
        for (int c = 0; c < light_grid_pkg::GRID_SIZE; c++) begin
            m[c] = (c >= first) && (c <= last);
        end
        return m;
    endfunction

    function automatic logic [light_grid_pkg::COUNT_WIDTH-1:0] ones(
        input logic [light_grid_pkg::GRID_SIZE-1:0] bits
    );
        logic [light_grid_pkg::COUNT_WIDTH-1:0] total;
        total = '0;
        for (int i = 0; i < light_grid_pkg::GRID_SIZE; i++) begin
            total = total + light_grid_pkg::COUNT_WIDTH'(bits[i]);
        end
        return total;
    endfunction

    row_memory u_rows (
        .clk     (clk),
        .rd_addr (row),
        .rd_data (rd_data),
        .wr_en   (wr_en),
        .wr_addr (row),
        .wr_data (wr_data)
    );

    always_comb begin
        case (op)
            light_grid_pkg::OP_ON:     new_row = rd_data | mask;
            light_grid_pkg::OP_OFF:    new_row = rd_data & ~mask;
            light_grid_pkg::OP_TOGGLE: new_row = rd_data ^ mask;
            default:                   new_row = rd_data;
        endcase
    end

    assign pop = (state == ST_WAIT) && not_empty;
    assign wr_en = (state == ST_CLEAR) || (state == ST_WRITE);
    assign wr_data = (state == ST_CLEAR) ? '0 : new_row;
    assign idle = (state == ST_WAIT) && !count_pending; // Count must settle too.

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_CLEAR;
            row <= '0;
            count_pending <= 1'b0;
            lit_count <= '0;
        end else begin
            count_pending <= (state == ST_WRITE);
            if (count_pending) begin
                lit_count <= lit_count + ones_new - ones_old;
            end
            case (state)
                ST_CLEAR: begin
                    if (row == light_grid_pkg::POSITION_WIDTH'(light_grid_pkg::GRID_SIZE - 1)) begin
                        state <= ST_WAIT;
                    end else begin
                        row <= row + 1'b1;
                    end
                end
                ST_WAIT: begin
                    if (not_empty) begin
                        row <= head.start_row;
                        state <= ST_READ;
                    end
                end
                ST_READ: state <= ST_WRITE;
                default: begin
                    if (row == end_row) begin
                        state <= ST_WAIT;
                    end else begin
                        row <= row + 1'b1;
                        state <= ST_READ;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            op <= head.op;
            end_row <= head.end_row;
            mask <= column_mask(head.start_col, head.end_col);
        end
        // Counted one cycle later, overlapping the next row's read.
        if (state == ST_WRITE) begin
            ones_new <= ones(new_row);
            ones_old <= ones(rd_data);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/light_grid_top.sv ====
`default_nettype none

module light_grid_top (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   in_valid,
    input  logic [light_grid_pkg::CHAR_WIDTH-1:0]  in_data,
    output logic                                   stall,
    output logic                                   done,
    output logic [light_grid_pkg::COUNT_WIDTH-1:0] lit_count
);

    light_grid_pkg::instr_t instr;
    light_grid_pkg::instr_t head;
    logic                   instr_valid;
    logic                   end_of_file;
    logic                   not_empty;
    logic                   pop;
    logic                   idle;

    line_decoder u_decoder (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .end_of_file (end_of_file),
        .instr_valid (instr_valid),
        .instr       (instr)
    );

    instr_queue u_queue (
        .clk       (clk),
        .reset     (reset),
        .push      (instr_valid),
        .push_data (instr),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty),
        .stall     (stall)
    );

    grid_engine u_engine (
        .clk       (clk),
        .reset     (reset),
        .not_empty (not_empty),
        .head      (head),
        .pop       (pop),
        .idle      (idle),
        .lit_count (lit_count)
    );

    // Sticky until the next reset.
    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else if (end_of_file && !not_empty && idle) begin
            done <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/light_grid_properties.sv ====
`default_nettype none

module light_grid_properties (
    input logic                                   clk,
    input logic                                   reset,
    input logic                                   done,
    input logic                                   push,
    input logic                                   pop,
    input logic [light_grid_pkg::COUNT_WIDTH-1:0] lit_count
);

    int occupancy; // Queue entries, tracked from push and pop.

    always_ff @(posedge clk) begin
        if (reset) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(push) - int'(pop);
        end
    end

    done_held: assert property (@(posedge clk) disable iff (reset) done |=> done)
        else $error("done fell while reset was low");

    no_push_when_full: assert property (@(posedge clk) disable iff (reset)
        push |-> occupancy < light_grid_pkg::QUEUE_DEPTH)
        else $error("instruction pushed into a full queue");

    count_in_range: assert property (@(posedge clk) disable iff (reset)
        lit_count <= light_grid_pkg::GRID_SIZE * light_grid_pkg::GRID_SIZE)
        else $error("lit count above the grid area");

endmodule

bind light_grid_top light_grid_properties u_properties (
    .clk       (clk),
    .reset     (reset),
    .done      (done),
    .push      (instr_valid),
    .pop       (pop),
    .lit_count (lit_count)
);

`default_nettype wire

// ==== testbench/light_grid_tb.sv ====
`default_nettype none

module light_grid_tb;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_GAP = 3;
    localparam int LINE_BYTES_MAX = 34;
    localparam int FILES_RUN = 7;
    localparam int INSTRS_RUN = 4 + 1 + 2 + 30 + 60 + 6;
    // Each file pays reset and clear sweep, each line its bytes and a full-height sweep.
    localparam longint WATCHDOG_CYCLES =
        2 * (FILES_RUN * (RESET_CYCLES + light_grid_pkg::GRID_SIZE + 8) +
             INSTRS_RUN * (LINE_BYTES_MAX * (MAX_GAP + 1) + 2 * light_grid_pkg::GRID_SIZE + 4));

    logic                                   clk;
    logic                                   reset;
    logic                                   in_valid;
    logic [light_grid_pkg::CHAR_WIDTH-1:0]  in_data;
    logic                                   stall;
    logic                                   done;
    logic [light_grid_pkg::COUNT_WIDTH-1:0] lit_count;

    logic [light_grid_pkg::GRID_SIZE-1:0] model_grid [light_grid_pkg::GRID_SIZE];
    int                                   model_count;
    logic [7:0]                           text_bytes [$];
    int                                   seed;
    logic                                 saw_stall;

    light_grid_top UUT (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .stall     (stall),
        .done      (done),
        .lit_count (lit_count)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Test failures found");
        $fatal(1, "Watchdog expired before the tests finished.");
    end

    task automatic check_value(input string name, input longint expected, input longint actual);
        if (expected != actual) begin
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "Value mismatch in %s.", name);
        end
    endtask

    // Model and text buffer start empty with the DUT.
    task automatic reset_dut();
        reset <= 1'b1;
        in_valid <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (int r = 0; r < light_grid_pkg::GRID_SIZE; r++) model_grid[r] = '0;
        model_count = 0;
        text_bytes.delete();
    endtask

    task automatic add_instruction(input light_grid_pkg::op_t op, input int start_row,
                                   input int start_col, input int end_row, input int end_col);
        string line;
        string op_name;
        logic  old_bit;
        logic  new_bit;
        case (op)
            light_grid_pkg::OP_ON:  op_name = "turn on";
            light_grid_pkg::OP_OFF: op_name = "turn off";
            default:                op_name = "toggle";
        endcase
        line = $sformatf("%s %0d,%0d through %0d,%0d\n", op_name, start_row, start_col,
                         end_row, end_col);
        for (int i = 0; i < line.len(); i++) text_bytes.push_back(line[i]);
        for (int r = start_row; r <= end_row; r++) begin
            for (int c = start_col; c <= end_col; c++) begin
                old_bit = model_grid[r][c];
                case (op)
                    light_grid_pkg::OP_ON:  new_bit = 1'b1;
                    light_grid_pkg::OP_OFF: new_bit = 1'b0;
                    default:                new_bit = ~old_bit;
                endcase
                model_grid[r][c] = new_bit;
                model_count = model_count + int'(new_bit) - int'(old_bit);
            end
        end
    endtask

    task automatic add_random_instruction(input logic one_row);
        int                  op_pick;
        int                  row_a;
        int                  row_b;
        int                  col_a;
        int                  col_b;
        light_grid_pkg::op_t op;
        op_pick = $unsigned($random(seed)) % 3;
        row_a = $unsigned($random(seed)) % light_grid_pkg::GRID_SIZE;
        row_b = one_row ? row_a : $unsigned($random(seed)) % light_grid_pkg::GRID_SIZE;
        col_a = $unsigned($random(seed)) % light_grid_pkg::GRID_SIZE;
        col_b = $unsigned($random(seed)) % light_grid_pkg::GRID_SIZE;
        case (op_pick)
            0:       op = light_grid_pkg::OP_OFF;
            1:       op = light_grid_pkg::OP_TOGGLE;
            default: op = light_grid_pkg::OP_ON;
        endcase
        add_instruction(op, (row_a < row_b) ? row_a : row_b, (col_a < col_b) ? col_a : col_b,
                        (row_a < row_b) ? row_b : row_a, (col_a < col_b) ? col_b : col_a);
    endtask

    // Called just after a rising edge; stall is read before the edge updates land.
    task automatic send_byte(input logic [7:0] value, input int gap);
        repeat (gap) begin
            in_valid <= 1'b0;
            @(posedge clk);
        end
        while (stall) begin
            saw_stall = 1'b1;
            in_valid <= 1'b0;
            @(posedge clk);
        end
        in_valid <= 1'b1;
        in_data <= value;
        @(posedge clk);
    endtask

    task automatic run_file(input string name, input int max_gap, input longint expected);
        for (int i = 0; i < text_bytes.size(); i++) begin
            send_byte(text_bytes[i], $unsigned($random(seed)) % (max_gap + 1));
        end
        check_value({name, " done before end of file"}, 0, done);
        send_byte(light_grid_pkg::CHAR_NUL, $unsigned($random(seed)) % (max_gap + 1));
        send_byte(light_grid_pkg::CHAR_NUL, $unsigned($random(seed)) % (max_gap + 1));
        in_valid <= 1'b0;
        while (!done) @(posedge clk);
        check_value(name, expected, lit_count);
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        in_valid = 1'b0;
        in_data = '0;
        seed = 32'h937b;
        saw_stall = 1'b0;

        reset_dut();
        add_instruction(light_grid_pkg::OP_ON, 0, 0, 9, 9);
        add_instruction(light_grid_pkg::OP_ON, 5, 5, 14, 14);
        add_instruction(light_grid_pkg::OP_ON, 100, 200, 102, 999);
        add_instruction(light_grid_pkg::OP_ON, 8, 0, 8, 999);
        run_file("turn_on_only", 1, 3560); // Union area of the four rectangles.

        reset_dut();
        add_instruction(light_grid_pkg::OP_ON, 0, 0, 999, 999);
        run_file("full_grid on", 0, 1000000);
        reset_dut();
        add_instruction(light_grid_pkg::OP_ON, 0, 0, 999, 999);
        add_instruction(light_grid_pkg::OP_TOGGLE, 0, 0, 999, 999);
        run_file("full_grid toggle", 0, 0);

        reset_dut();
        repeat (30) add_random_instruction(1'b0);
        run_file("mixed_random", MAX_GAP, model_count);

        // Queue fills during the clear sweep.
        reset_dut();
        saw_stall = 1'b0;
        repeat (60) add_random_instruction(1'b1);
        run_file("burst_stall", 0, model_count);
        check_value("burst_stall stall raised", 1, saw_stall);

        reset_dut();
        repeat (3) add_random_instruction(1'b0);
        run_file("reset_between first", 1, model_count);
        reset_dut();
        check_value("reset_between done after reset", 0, done);
        check_value("reset_between count after reset", 0, lit_count);
        repeat (3) add_random_instruction(1'b0);
        run_file("reset_between second", 1, model_count);

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== light_grid_top.f ====
common/light_grid_pkg.sv
hdl/line_decoder.sv
hdl/instr_queue.sv
grid_engine/row_memory.sv
grid_engine/grid_engine.sv
hdl/light_grid_top.sv
testbench/light_grid_properties.sv
testbench/light_grid_tb.sv

// ==== build.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    --top-module light_grid_tb -f light_grid_top.f \
    --Mdir obj_dir -o light_grid_sim
./obj_dir/light_grid_sim
